//--- csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define CSR_ADDR_W 14
`define CSR_DATA_W 32
`define INT_W      13  // SWI 2, HWI 8, reserved, TI, IPI
`define SAVE_N     4

// Register addresses
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ECFG   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_BADV   14'h007
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044

// Writable bits per register
`define MASK_CRMD   32'h0000_01ff
`define MASK_PRMD   32'h0000_0007
`define MASK_ECFG   32'h0000_1bff  // LIE without bit 10
`define MASK_ESTAT  32'h0000_0003  // Software interrupts only
`define MASK_ERA    32'hffff_ffff
`define MASK_BADV   32'hffff_ffff
`define MASK_EENTRY 32'hffff_ffc0
`define MASK_SAVE   32'hffff_ffff
`define MASK_TCFG   32'hffff_ffff
`define MASK_TICLR  32'h0000_0001

`define CRMD_RESET 32'h0000_0008  // PLV0, IE off, DA on
`define TVAL_RESET 32'hffff_ffff

`endif

//--- csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

    // Target of a decoded software write
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_CRMD, SEL_PRMD, SEL_ECFG, SEL_ESTAT,
        SEL_ERA, SEL_BADV, SEL_EENTRY,
        SEL_SAVE0, SEL_SAVE1, SEL_SAVE2, SEL_SAVE3,  // Must stay consecutive
        SEL_TCFG, SEL_TICLR
    } csr_sel_e;

    // Value is the ESTAT ecode
    typedef enum logic [5:0] {
        EXC_INT = 6'h00,
        EXC_ADE = 6'h08,
        EXC_ALE = 6'h09,
        EXC_SYS = 6'h0b,
        EXC_BRK = 6'h0c,
        EXC_INE = 6'h0d,
        EXC_IPE = 6'h0e
    } exc_cause_e;

    function automatic logic [`CSR_DATA_W-1:0] masked_merge(
        input logic [`CSR_DATA_W-1:0] cur,
        input logic [`CSR_DATA_W-1:0] data,
        input logic [`CSR_DATA_W-1:0] mask
    );
        return (cur & ~mask) | (data & mask);
    endfunction

endpackage

//--- csr_wr_if.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

interface csr_wr_if;
    import csr_pkg::*;

    logic                   wr_valid;  // One-cycle strobe, always accepted
    csr_sel_e               wr_sel;
    logic [`CSR_DATA_W-1:0] wr_data;
    logic [`CSR_DATA_W-1:0] wr_mask;

    modport src (
        output wr_valid,
        output wr_sel,
        output wr_data,
        output wr_mask
    );

    modport dst (
        input wr_valid,
        input wr_sel,
        input wr_data,
        input wr_mask
    );
endinterface

//--- csr_write_decode.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_write_decode (
    input  logic                   csr_we_i,
    input  logic [`CSR_ADDR_W-1:0] csr_waddr_i,
    input  logic [`CSR_DATA_W-1:0] csr_wdata_i,
    csr_wr_if.src                  wr
);
    import csr_pkg::*;

    csr_sel_e               sel;
    logic [`CSR_DATA_W-1:0] mask;

    always_comb begin
        sel  = SEL_NONE;
        mask = '0;
        case (csr_waddr_i)
            `CSR_CRMD: begin
                sel  = SEL_CRMD;
                mask = `MASK_CRMD;
            end
            `CSR_PRMD: begin
                sel  = SEL_PRMD;
                mask = `MASK_PRMD;
            end
            `CSR_ECFG: begin
                sel  = SEL_ECFG;
                mask = `MASK_ECFG;
            end
            `CSR_ESTAT: begin
                sel  = SEL_ESTAT;
                mask = `MASK_ESTAT;
            end
            `CSR_ERA: begin
                sel  = SEL_ERA;
                mask = `MASK_ERA;
            end
            `CSR_BADV: begin
                sel  = SEL_BADV;
                mask = `MASK_BADV;
            end
            `CSR_EENTRY: begin
                sel  = SEL_EENTRY;
                mask = `MASK_EENTRY;
            end
            `CSR_SAVE0: begin
                sel  = SEL_SAVE0;
                mask = `MASK_SAVE;
            end
            `CSR_SAVE1: begin
                sel  = SEL_SAVE1;
                mask = `MASK_SAVE;
            end
            `CSR_SAVE2: begin
                sel  = SEL_SAVE2;
                mask = `MASK_SAVE;
            end
            `CSR_SAVE3: begin
                sel  = SEL_SAVE3;
                mask = `MASK_SAVE;
            end
            `CSR_TCFG: begin
                sel  = SEL_TCFG;
                mask = `MASK_TCFG;
            end
            `CSR_TICLR: begin
                sel  = SEL_TICLR;
                mask = `MASK_TICLR;
            end
            default: begin
                sel  = SEL_NONE;  // TVAL is read-only
                mask = '0;
            end
        endcase
    end

    assign wr.wr_valid = csr_we_i && (sel != SEL_NONE);
    assign wr.wr_sel   = sel;
    assign wr.wr_data  = csr_wdata_i;
    assign wr.wr_mask  = mask;

endmodule

//--- csr_exc_regs.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_exc_regs (
    input  logic                   clk,
    input  logic                   rst,
    csr_wr_if.dst                  wr,
    input  logic                   exc_valid_i,
    input  csr_pkg::exc_cause_e    exc_cause_i,
    input  logic [8:0]             exc_esubcode_i,
    input  logic [`CSR_DATA_W-1:0] exc_pc_i,
    input  logic [`CSR_DATA_W-1:0] exc_badaddr_i,
    input  logic                   ertn_i,
    input  logic [7:0]             hwi_i,
    input  logic                   ipi_i,
    input  logic                   ti_i,
    output logic [`CSR_DATA_W-1:0] crmd_o,
    output logic [`CSR_DATA_W-1:0] prmd_o,
    output logic [`CSR_DATA_W-1:0] ecfg_o,
    output logic [`CSR_DATA_W-1:0] estat_o,
    output logic [`CSR_DATA_W-1:0] era_o,
    output logic [`CSR_DATA_W-1:0] badv_o,
    output logic [`CSR_DATA_W-1:0] eentry_o,
    output logic [1:0]             plv_o,
    output logic                   irq_o
);
    import csr_pkg::*;

    logic [`CSR_DATA_W-1:0] crmd;
    logic [`CSR_DATA_W-1:0] prmd;
    logic [`CSR_DATA_W-1:0] ecfg;
    logic [`CSR_DATA_W-1:0] estat;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] badv;
    logic [`CSR_DATA_W-1:0] eentry;

    logic we_crmd;
    logic we_prmd;
    logic we_ecfg;
    logic we_estat;
    logic we_era;
    logic we_badv;
    logic we_eentry;
    logic badv_from_addr;
    logic badv_from_pc;

    assign we_crmd   = wr.wr_valid && (wr.wr_sel == SEL_CRMD);
    assign we_prmd   = wr.wr_valid && (wr.wr_sel == SEL_PRMD);
    assign we_ecfg   = wr.wr_valid && (wr.wr_sel == SEL_ECFG);
    assign we_estat  = wr.wr_valid && (wr.wr_sel == SEL_ESTAT);
    assign we_era    = wr.wr_valid && (wr.wr_sel == SEL_ERA);
    assign we_badv   = wr.wr_valid && (wr.wr_sel == SEL_BADV);
    assign we_eentry = wr.wr_valid && (wr.wr_sel == SEL_EENTRY);

    // Fetch ADE (subcode 0) faults on the PC itself
    assign badv_from_addr = (exc_cause_i == EXC_ALE) ||
                            (exc_cause_i == EXC_ADE && exc_esubcode_i != 9'd0);
    assign badv_from_pc   = (exc_cause_i == EXC_ADE) && (exc_esubcode_i == 9'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= `CRMD_RESET;
        end else if (exc_valid_i) begin
            crmd[2:0] <= 3'b000;  // PLV0, IE off
        end else if (ertn_i) begin
            crmd[2:0] <= prmd[2:0];
        end else if (we_crmd) begin
            crmd <= masked_merge(crmd, wr.wr_data, wr.wr_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (exc_valid_i) begin
            prmd[2:0] <= crmd[2:0];  // PPLV and PIE
        end else if (we_prmd) begin
            prmd <= masked_merge(prmd, wr.wr_data, wr.wr_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg <= '0;
        end else if (we_ecfg) begin
            ecfg <= masked_merge(ecfg, wr.wr_data, wr.wr_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat <= '0;
        end else begin
            if (exc_valid_i) begin
                estat[21:16] <= exc_cause_i;
                estat[31:22] <= {1'b0, exc_esubcode_i};
            end else if (we_estat) begin
                estat <= masked_merge(estat, wr.wr_data, wr.wr_mask);
            end
            // Interrupt lines sampled every cycle
            estat[9:2] <= hwi_i;
            estat[11]  <= ti_i;
            estat[12]  <= ipi_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era <= '0;
        end else if (exc_valid_i) begin
            era <= exc_pc_i;
        end else if (we_era) begin
            era <= masked_merge(era, wr.wr_data, wr.wr_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badv <= '0;
        end else if (exc_valid_i) begin
            if (badv_from_addr) begin
                badv <= exc_badaddr_i;
            end else if (badv_from_pc) begin
                badv <= exc_pc_i;
            end
        end else if (we_badv) begin
            badv <= masked_merge(badv, wr.wr_data, wr.wr_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eentry <= '0;
        end else if (we_eentry) begin
            eentry <= masked_merge(eentry, wr.wr_data, wr.wr_mask);
        end
    end

    assign irq_o = crmd[2] && |(ecfg[`INT_W-1:0] & estat[`INT_W-1:0]);

    assign crmd_o   = crmd;
    assign prmd_o   = prmd;
    assign ecfg_o   = ecfg;
    assign estat_o  = estat;
    assign era_o    = era;
    assign badv_o   = badv;
    assign eentry_o = eentry;
    assign plv_o    = crmd[1:0];

endmodule

//--- csr_timer.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_timer (
    input  logic                   clk,
    input  logic                   rst,
    csr_wr_if.dst                  wr,
    output logic [`CSR_DATA_W-1:0] tcfg_o,
    output logic [`CSR_DATA_W-1:0] tval_o,
    output logic                   ti_o
);
    import csr_pkg::*;

    logic [`CSR_DATA_W-1:0] tcfg;
    logic [`CSR_DATA_W-1:0] tcfg_new;
    logic [`CSR_DATA_W-1:0] tval;
    logic                   timer_on;  // Cleared by one-shot expiry
    logic                   pending;
    logic                   we_tcfg;
    logic                   clr_ti;
    logic                   expire;

    assign we_tcfg  = wr.wr_valid && (wr.wr_sel == SEL_TCFG);
    assign clr_ti   = wr.wr_valid && (wr.wr_sel == SEL_TICLR) && wr.wr_data[0] && wr.wr_mask[0];
    assign tcfg_new = masked_merge(tcfg, wr.wr_data, wr.wr_mask);
    assign expire   = timer_on && (tval == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg     <= '0;
            tval     <= `TVAL_RESET;
            timer_on <= 1'b0;
        end else if (we_tcfg) begin
            tcfg     <= tcfg_new;
            tval     <= {tcfg_new[`CSR_DATA_W-1:2], 2'b00};
            timer_on <= tcfg_new[0];
        end else if (expire) begin
            if (tcfg[1]) begin
                tval <= {tcfg[`CSR_DATA_W-1:2], 2'b00};  // Periodic reload
            end else begin
                timer_on <= 1'b0;
            end
        end else if (timer_on) begin
            tval <= tval - 1'b1;
        end
    end

    // Expiry wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (expire) begin
            pending <= 1'b1;
        end else if (clr_ti) begin
            pending <= 1'b0;
        end
    end

    assign tcfg_o = tcfg;
    assign tval_o = tval;
    assign ti_o   = pending;

endmodule

//--- csr_save_bank.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_save_bank (
    input  logic                   clk,
    input  logic                   rst,
    csr_wr_if.dst                  wr,
    output logic [`CSR_DATA_W-1:0] save_o [`SAVE_N]
);
    import csr_pkg::*;

    for (genvar i = 0; i < `SAVE_N; i++) begin : g_save
        localparam csr_sel_e MY_SEL = csr_sel_e'(SEL_SAVE0 + i);

        logic [`CSR_DATA_W-1:0] q;

        always_ff @(posedge clk) begin
            if (rst) begin
                q <= '0;
            end else if (wr.wr_valid && (wr.wr_sel == MY_SEL)) begin
                q <= masked_merge(q, wr.wr_data, wr.wr_mask);
            end
        end

        assign save_o[i] = q;
    end

endmodule

//--- csr_read_mux.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_read_mux (
    input  logic [`CSR_ADDR_W-1:0] csr_raddr_i,
    input  logic [`CSR_DATA_W-1:0] crmd_i,
    input  logic [`CSR_DATA_W-1:0] prmd_i,
    input  logic [`CSR_DATA_W-1:0] ecfg_i,
    input  logic [`CSR_DATA_W-1:0] estat_i,
    input  logic [`CSR_DATA_W-1:0] era_i,
    input  logic [`CSR_DATA_W-1:0] badv_i,
    input  logic [`CSR_DATA_W-1:0] eentry_i,
    input  logic [`CSR_DATA_W-1:0] save_i [`SAVE_N],
    input  logic [`CSR_DATA_W-1:0] tcfg_i,
    input  logic [`CSR_DATA_W-1:0] tval_i,
    output logic [`CSR_DATA_W-1:0] csr_rdata_o
);

    always_comb begin
        case (csr_raddr_i)
            `CSR_CRMD:   csr_rdata_o = crmd_i;
            `CSR_PRMD:   csr_rdata_o = prmd_i;
            `CSR_ECFG:   csr_rdata_o = ecfg_i;
            `CSR_ESTAT:  csr_rdata_o = estat_i;
            `CSR_ERA:    csr_rdata_o = era_i;
            `CSR_BADV:   csr_rdata_o = badv_i;
            `CSR_EENTRY: csr_rdata_o = eentry_i;
            `CSR_SAVE0:  csr_rdata_o = save_i[0];
            `CSR_SAVE1:  csr_rdata_o = save_i[1];
            `CSR_SAVE2:  csr_rdata_o = save_i[2];
            `CSR_SAVE3:  csr_rdata_o = save_i[3];
            `CSR_TCFG:   csr_rdata_o = tcfg_i;
            `CSR_TVAL:   csr_rdata_o = tval_i;
            default:     csr_rdata_o = '0;  // TICLR has no readable state
        endcase
    end

endmodule

//--- csr_top.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   csr_we_i,
    input  logic [`CSR_ADDR_W-1:0] csr_waddr_i,
    input  logic [`CSR_DATA_W-1:0] csr_wdata_i,
    input  logic [`CSR_ADDR_W-1:0] csr_raddr_i,
    output logic [`CSR_DATA_W-1:0] csr_rdata_o,
    input  logic                   exc_valid_i,
    input  csr_pkg::exc_cause_e    exc_cause_i,
    input  logic [8:0]             exc_esubcode_i,
    input  logic [`CSR_DATA_W-1:0] exc_pc_i,
    input  logic [`CSR_DATA_W-1:0] exc_badaddr_i,
    input  logic                   ertn_i,
    input  logic [7:0]             hwi_i,
    input  logic                   ipi_i,
    output logic [`CSR_DATA_W-1:0] eentry_o,
    output logic [`CSR_DATA_W-1:0] era_o,
    output logic [1:0]             plv_o,
    output logic                   irq_o
);

    logic [`CSR_DATA_W-1:0] crmd;
    logic [`CSR_DATA_W-1:0] prmd;
    logic [`CSR_DATA_W-1:0] ecfg;
    logic [`CSR_DATA_W-1:0] estat;
    logic [`CSR_DATA_W-1:0] badv;
    logic [`CSR_DATA_W-1:0] tcfg;
    logic [`CSR_DATA_W-1:0] tval;
    logic [`CSR_DATA_W-1:0] save [`SAVE_N];
    logic                   ti;

    csr_wr_if wr_bus ();

    csr_write_decode u_decode (
        .csr_we_i    (csr_we_i),
        .csr_waddr_i (csr_waddr_i),
        .csr_wdata_i (csr_wdata_i),
        .wr          (wr_bus.src)
    );

    csr_exc_regs u_exc (
        .clk            (clk),
        .rst            (rst),
        .wr             (wr_bus.dst),
        .exc_valid_i    (exc_valid_i),
        .exc_cause_i    (exc_cause_i),
        .exc_esubcode_i (exc_esubcode_i),
        .exc_pc_i       (exc_pc_i),
        .exc_badaddr_i  (exc_badaddr_i),
        .ertn_i         (ertn_i),
        .hwi_i          (hwi_i),
        .ipi_i          (ipi_i),
        .ti_i           (ti),
        .crmd_o         (crmd),
        .prmd_o         (prmd),
        .ecfg_o         (ecfg),
        .estat_o        (estat),
        .era_o          (era_o),
        .badv_o         (badv),
        .eentry_o       (eentry_o),
        .plv_o          (plv_o),
        .irq_o          (irq_o)
    );

    csr_timer u_timer (
        .clk    (clk),
        .rst    (rst),
        .wr     (wr_bus.dst),
        .tcfg_o (tcfg),
        .tval_o (tval),
        .ti_o   (ti)
    );

    csr_save_bank u_save (
        .clk    (clk),
        .rst    (rst),
        .wr     (wr_bus.dst),
        .save_o (save)
    );

    csr_read_mux u_rmux (
        .csr_raddr_i (csr_raddr_i),
        .crmd_i      (crmd),
        .prmd_i      (prmd),
        .ecfg_i      (ecfg),
        .estat_i     (estat),
        .era_i       (era_o),
        .badv_i      (badv),
        .eentry_i    (eentry_o),
        .save_i      (save),
        .tcfg_i      (tcfg),
        .tval_i      (tval),
        .csr_rdata_o (csr_rdata_o)
    );

endmodule

//--- tb_csr.sv
`timescale 1ns/1ns
`include "csr_defs.svh"

module tb_csr;
    import csr_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int PLANNED_CYCLES = 300;
    localparam int MARGIN_CYCLES  = 200;

    localparam logic [`CSR_ADDR_W-1:0] WR_ADDRS [11] = '{
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_CRMD, `CSR_PRMD,
        `CSR_ECFG, `CSR_EENTRY, `CSR_ERA, `CSR_BADV, `CSR_ESTAT
    };

    logic                   clk;
    logic                   rst;
    logic                   csr_we_i;
    logic [`CSR_ADDR_W-1:0] csr_waddr_i;
    logic [`CSR_DATA_W-1:0] csr_wdata_i;
    logic [`CSR_ADDR_W-1:0] csr_raddr_i;
    logic [`CSR_DATA_W-1:0] csr_rdata_o;
    logic                   exc_valid_i;
    exc_cause_e             exc_cause_i;
    logic [8:0]             exc_esubcode_i;
    logic [`CSR_DATA_W-1:0] exc_pc_i;
    logic [`CSR_DATA_W-1:0] exc_badaddr_i;
    logic                   ertn_i;
    logic [7:0]             hwi_i;
    logic                   ipi_i;
    logic [`CSR_DATA_W-1:0] eentry_o;
    logic [`CSR_DATA_W-1:0] era_o;
    logic [1:0]             plv_o;
    logic                   irq_o;

    // Reference model state
    logic [`CSR_DATA_W-1:0] m_crmd;
    logic [`CSR_DATA_W-1:0] m_prmd;
    logic [`CSR_DATA_W-1:0] m_ecfg;
    logic [`CSR_DATA_W-1:0] m_estat;
    logic [`CSR_DATA_W-1:0] m_era;
    logic [`CSR_DATA_W-1:0] m_badv;
    logic [`CSR_DATA_W-1:0] m_eentry;
    logic [`CSR_DATA_W-1:0] m_save [`SAVE_N];
    logic [`CSR_DATA_W-1:0] m_tcfg;
    logic [`CSR_DATA_W-1:0] m_tval;
    logic                   m_on;
    logic                   m_pend;

    logic [31:0] rng;
    int          checks;
    int          rd_errors;
    int          irq_errors;
    int          misc_errors;

    csr_top uut (
        .clk            (clk),
        .rst            (rst),
        .csr_we_i       (csr_we_i),
        .csr_waddr_i    (csr_waddr_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_raddr_i    (csr_raddr_i),
        .csr_rdata_o    (csr_rdata_o),
        .exc_valid_i    (exc_valid_i),
        .exc_cause_i    (exc_cause_i),
        .exc_esubcode_i (exc_esubcode_i),
        .exc_pc_i       (exc_pc_i),
        .exc_badaddr_i  (exc_badaddr_i),
        .ertn_i         (ertn_i),
        .hwi_i          (hwi_i),
        .ipi_i          (ipi_i),
        .eentry_o       (eentry_o),
        .era_o          (era_o),
        .plv_o          (plv_o),
        .irq_o          (irq_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] mask_of(input logic [`CSR_ADDR_W-1:0] a);
        case (a)
            `CSR_CRMD:   return `MASK_CRMD;
            `CSR_PRMD:   return `MASK_PRMD;
            `CSR_ECFG:   return `MASK_ECFG;
            `CSR_ESTAT:  return `MASK_ESTAT;
            `CSR_ERA:    return `MASK_ERA;
            `CSR_BADV:   return `MASK_BADV;
            `CSR_EENTRY: return `MASK_EENTRY;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3: return `MASK_SAVE;
            `CSR_TCFG:   return `MASK_TCFG;
            default:     return 32'h0;
        endcase
    endfunction

    // Model register after this cycle's software write, if it targets a
    function automatic logic [31:0] apply_write(input logic [`CSR_ADDR_W-1:0] a,
                                                input logic [31:0] old);
        if (csr_we_i && csr_waddr_i == a) begin
            return (old & ~mask_of(a)) | (csr_wdata_i & mask_of(a));
        end
        return old;
    endfunction

    function automatic logic [31:0] exp_read(input logic [`CSR_ADDR_W-1:0] a);
        case (a)
            `CSR_CRMD:   return m_crmd;
            `CSR_PRMD:   return m_prmd;
            `CSR_ECFG:   return m_ecfg;
            `CSR_ESTAT:  return m_estat;
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return m_eentry;
            `CSR_SAVE0:  return m_save[0];
            `CSR_SAVE1:  return m_save[1];
            `CSR_SAVE2:  return m_save[2];
            `CSR_SAVE3:  return m_save[3];
            `CSR_TCFG:   return m_tcfg;
            `CSR_TVAL:   return m_tval;
            default:     return 32'h0;
        endcase
    endfunction

    task automatic model_reset();
        m_crmd   = `CRMD_RESET;
        m_prmd   = '0;
        m_ecfg   = '0;
        m_estat  = '0;
        m_era    = '0;
        m_badv   = '0;
        m_eentry = '0;
        for (int i = 0; i < `SAVE_N; i++) begin
            m_save[i] = '0;
        end
        m_tcfg = '0;
        m_tval = `TVAL_RESET;
        m_on   = 1'b0;
        m_pend = 1'b0;
    endtask

    // Applies one clock edge using the inputs held during the cycle
    task automatic model_update();
        logic [31:0] old_crmd;
        logic [31:0] old_prmd;
        logic        old_pend;
        logic        expire;
        if (rst) begin
            model_reset();
            return;
        end
        old_crmd = m_crmd;
        old_prmd = m_prmd;
        old_pend = m_pend;
        expire   = m_on && (m_tval == 32'h0);
        if (exc_valid_i) begin
            m_crmd[2:0]    = 3'b000;
            m_prmd[2:0]    = old_crmd[2:0];
            m_era          = exc_pc_i;
            m_estat[21:16] = exc_cause_i;
            m_estat[31:22] = {1'b0, exc_esubcode_i};
            if (exc_cause_i == EXC_ALE) begin
                m_badv = exc_badaddr_i;
            end else if (exc_cause_i == EXC_ADE) begin
                m_badv = (exc_esubcode_i != 9'd0) ? exc_badaddr_i : exc_pc_i;
            end
        end else begin
            if (ertn_i) begin
                m_crmd[2:0] = old_prmd[2:0];
            end else begin
                m_crmd = apply_write(`CSR_CRMD, m_crmd);
            end
            m_prmd  = apply_write(`CSR_PRMD, m_prmd);
            m_estat = apply_write(`CSR_ESTAT, m_estat);
            m_era   = apply_write(`CSR_ERA, m_era);
            m_badv  = apply_write(`CSR_BADV, m_badv);
        end
        m_ecfg   = apply_write(`CSR_ECFG, m_ecfg);
        m_eentry = apply_write(`CSR_EENTRY, m_eentry);
        for (int i = 0; i < `SAVE_N; i++) begin
            m_save[i] = apply_write(14'(`CSR_SAVE0 + i), m_save[i]);
        end
        m_estat[9:2] = hwi_i;
        m_estat[11]  = old_pend;
        m_estat[12]  = ipi_i;
        if (csr_we_i && csr_waddr_i == `CSR_TCFG) begin
            m_tcfg = apply_write(`CSR_TCFG, m_tcfg);
            m_tval = {m_tcfg[31:2], 2'b00};
            m_on   = m_tcfg[0];
        end else if (expire) begin
            if (m_tcfg[1]) begin
                m_tval = {m_tcfg[31:2], 2'b00};
            end else begin
                m_on = 1'b0;
            end
        end else if (m_on) begin
            m_tval = m_tval - 32'd1;
        end
        if (expire) begin
            m_pend = 1'b1;
        end else if (csr_we_i && csr_waddr_i == `CSR_TICLR && csr_wdata_i[0]) begin
            m_pend = 1'b0;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        model_update();
        csr_we_i    = 1'b0;
        exc_valid_i = 1'b0;
        ertn_i      = 1'b0;
    endtask

    task automatic read_cycle(input logic [`CSR_ADDR_W-1:0] a);
        csr_raddr_i = a;
        tick();
    endtask

    task automatic write_csr(input logic [`CSR_ADDR_W-1:0] a, input logic [31:0] d);
        csr_we_i    = 1'b1;
        csr_waddr_i = a;
        csr_wdata_i = d;
        csr_raddr_i = a;
        tick();
    endtask

    // One exception cycle with a software write to clash in the same cycle
    task automatic raise_exc(input exc_cause_e cause, input logic [8:0] sub,
                             input logic [`CSR_ADDR_W-1:0] clash);
        write_csr(`CSR_CRMD, next_rand());
        write_csr(`CSR_BADV, next_rand());
        exc_valid_i    = 1'b1;
        exc_cause_i    = cause;
        exc_esubcode_i = sub;
        exc_pc_i       = next_rand();
        exc_badaddr_i  = next_rand();
        csr_we_i       = 1'b1;
        csr_waddr_i    = clash;
        csr_wdata_i    = next_rand();
        csr_raddr_i    = `CSR_CRMD;
        tick();
        read_cycle(`CSR_PRMD);
        read_cycle(`CSR_ESTAT);
        read_cycle(`CSR_BADV);
        read_cycle(`CSR_CRMD);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            checks++;
            assert (csr_rdata_o === exp_read(csr_raddr_i)) else begin
                rd_errors++;
                $display("ERR %0t csr_rdata_o[%h] exp %h got %h", $time, csr_raddr_i,
                         exp_read(csr_raddr_i), csr_rdata_o);
            end
            assert (eentry_o === m_eentry) else begin
                rd_errors++;
                $display("ERR %0t eentry_o exp %h got %h", $time, m_eentry, eentry_o);
            end
            assert (era_o === m_era) else begin
                rd_errors++;
                $display("ERR %0t era_o exp %h got %h", $time, m_era, era_o);
            end
            assert (plv_o === m_crmd[1:0]) else begin
                rd_errors++;
                $display("ERR %0t plv_o exp %h got %h", $time, m_crmd[1:0], plv_o);
            end
        end
    end

    irq_matches: assert property (@(negedge clk) disable iff (rst)
        irq_o == (m_crmd[2] && (|(m_ecfg[`INT_W-1:0] & m_estat[`INT_W-1:0]))))
    else begin
        irq_errors++;
        $display("ERR %0t irq_o exp %b got %b", $time,
                 m_crmd[2] && (|(m_ecfg[`INT_W-1:0] & m_estat[`INT_W-1:0])), irq_o);
    end

    initial begin
        #((PLANNED_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: stimulus did not finish within %0d cycles",
                 PLANNED_CYCLES + MARGIN_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic        prev_ti;
        int          ti_rises;
        clk            = 1'b0;
        rst            = 1'b1;
        csr_we_i       = 1'b0;
        csr_waddr_i    = '0;
        csr_wdata_i    = '0;
        csr_raddr_i    = '0;
        exc_valid_i    = 1'b0;
        exc_cause_i    = EXC_INT;
        exc_esubcode_i = '0;
        exc_pc_i       = '0;
        exc_badaddr_i  = '0;
        ertn_i         = 1'b0;
        hwi_i          = '0;
        ipi_i          = 1'b0;
        rng            = 32'hea94;
        checks         = 0;
        rd_errors      = 0;
        irq_errors     = 0;
        misc_errors    = 0;
        prev_ti        = 1'b0;
        ti_rises       = 0;
        model_reset();
        repeat (16) tick();
        rst = 1'b0;

        // Masked write and readback
        foreach (WR_ADDRS[i]) begin
            write_csr(WR_ADDRS[i], next_rand());
            read_cycle(WR_ADDRS[i]);
        end
        write_csr(`CSR_TVAL, next_rand());  // Read-only
        read_cycle(`CSR_TVAL);
        write_csr(14'h002, next_rand());
        read_cycle(`CSR_TICLR);
        read_cycle(14'h3ff);
        r = next_rand();
        read_cycle(r[`CSR_ADDR_W-1:0]);

        // Exception entry, each with a clashing write
        raise_exc(EXC_INT, 9'd0, `CSR_ERA);
        raise_exc(EXC_ADE, 9'd0, `CSR_BADV);
        raise_exc(EXC_ADE, 9'd1, `CSR_CRMD);
        raise_exc(EXC_ALE, 9'd0, `CSR_PRMD);
        raise_exc(EXC_SYS, 9'd0, `CSR_ESTAT);
        raise_exc(EXC_BRK, 9'd3, `CSR_BADV);
        raise_exc(EXC_INE, 9'd0, `CSR_ERA);
        raise_exc(EXC_IPE, 9'd0, `CSR_CRMD);

        // Return, then return together with an exception
        write_csr(`CSR_PRMD, next_rand());
        ertn_i      = 1'b1;
        csr_raddr_i = `CSR_CRMD;
        tick();
        read_cycle(`CSR_CRMD);
        write_csr(`CSR_PRMD, 32'h0000_0007);
        write_csr(`CSR_CRMD, 32'h0000_0005);
        exc_valid_i = 1'b1;
        ertn_i      = 1'b1;
        exc_cause_i = EXC_SYS;
        exc_pc_i    = next_rand();
        tick();
        read_cycle(`CSR_PRMD);
        read_cycle(`CSR_CRMD);

        // Interrupt mirroring and request
        write_csr(`CSR_CRMD, 32'h0000_0004);
        for (int i = 0; i < 40; i++) begin
            r     = next_rand();
            hwi_i = r[7:0];
            ipi_i = r[8];
            if (i % 5 == 0) begin
                csr_we_i    = 1'b1;
                csr_waddr_i = `CSR_ECFG;
                csr_wdata_i = next_rand();
            end else if (i % 7 == 0) begin
                csr_we_i    = 1'b1;
                csr_waddr_i = `CSR_CRMD;
                csr_wdata_i = {29'd0, r[9], 2'b00};
            end
            csr_raddr_i = `CSR_ESTAT;
            tick();
        end
        hwi_i = '0;
        ipi_i = 1'b0;
        write_csr(`CSR_ECFG, 32'h0000_0800);  // Timer line only

        // One-shot timer with initial value 20
        write_csr(`CSR_TCFG, 32'd20 | 32'd1);
        repeat (26) read_cycle(`CSR_TVAL);
        repeat (4) read_cycle(`CSR_ESTAT);
        assert (csr_rdata_o[11] === 1'b1) else begin
            misc_errors++;
            $display("ERR %0t estat[11] exp 1 got %b", $time, csr_rdata_o[11]);
        end
        write_csr(`CSR_TICLR, 32'h1);
        repeat (3) read_cycle(`CSR_ESTAT);

        // Periodic timer with initial value 12, cleared now and then
        write_csr(`CSR_TCFG, 32'd12 | 32'd3);
        for (int i = 0; i < 50; i++) begin
            if (i % 16 == 15) begin
                write_csr(`CSR_TICLR, 32'h1);
            end else if (i % 2 == 0) begin
                read_cycle(`CSR_TVAL);
            end else begin
                read_cycle(`CSR_ESTAT);
                if (csr_rdata_o[11] && !prev_ti) begin
                    ti_rises++;
                end
                prev_ti = csr_rdata_o[11];
            end
        end
        // Period of 13 cycles gives three expiries in 50
        assert (ti_rises >= 3) else begin
            misc_errors++;
            $display("Periodic timer pending bit rose %0d times, expected at least 3",
                     ti_rises);
        end
        write_csr(`CSR_TCFG, 32'h0);
        read_cycle(`CSR_TVAL);

        $display("Checks %0d, read errors %0d, irq errors %0d, other errors %0d",
                 checks, rd_errors, irq_errors, misc_errors);
        if (rd_errors + irq_errors + misc_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+.
csr_pkg.sv
csr_wr_if.sv
csr_write_decode.sv
csr_exc_regs.sv
csr_timer.sv
csr_save_bank.sv
csr_read_mux.sv
csr_top.sv
tb_csr.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_csr -f files.f -o tb_csr_sim
./obj_dir/tb_csr_sim > sim.log 2>&1
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
